//--- common/rv_core_config.svh
// Core sizing for RV32I only; the decoder immediates assume XLEN is 32
`ifndef RV_CORE_CONFIG_SVH
`define RV_CORE_CONFIG_SVH

// Data and address width
`define XLEN 32

// Register index width and register count
`define REG_ADDR_W 5
`define NUM_REGS 32

// First fetch address after reset
`define RESET_PC 32'h0000_0000

// ADDI x0, x0, 0
`define NOP_INST 32'h0000_0013

`endif

//--- common/rv_core_pkg.sv
// Shared types for the five-stage core; field widths follow rv_core_config.svh
`include "rv_core_config.svh"

package rv_core_pkg;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLL,
        ALU_SRL,
        ALU_SRA,
        ALU_SLT
    } alu_op_e;

    // Operand source for the EX stage
    typedef enum logic [1:0] {
        FWD_REG = 2'b00,
        FWD_WB  = 2'b01,
        FWD_MEM = 2'b10
    } fwd_sel_e;

    typedef struct packed {
        logic [`XLEN-1:0] pc;
        logic [`XLEN-1:0] inst;
    } if_id_t;

    typedef struct packed {
        logic [`XLEN-1:0]       pc;
        logic [`XLEN-1:0]       rs1_val;
        logic [`XLEN-1:0]       rs2_val;
        logic [`XLEN-1:0]       imm;
        logic [`REG_ADDR_W-1:0] rs1;
        logic [`REG_ADDR_W-1:0] rs2;
        logic [`REG_ADDR_W-1:0] rd;
        alu_op_e                alu_op;
        logic                   alu_src;    // Immediate as ALU operand b
        logic                   reg_write;
        logic                   mem_read;
        logic                   mem_write;
        logic                   branch;
        logic                   branch_ne;  // Inverts the equality test
        logic                   jal;
        logic                   jalr;
    } id_ex_t;

    typedef struct packed {
        logic [`XLEN-1:0]       result;     // ALU result or link address
        logic [`XLEN-1:0]       store_data;
        logic [`REG_ADDR_W-1:0] rd;
        logic                   reg_write;
        logic                   mem_read;
        logic                   mem_write;
    } ex_mem_t;

    typedef struct packed {
        logic [`XLEN-1:0]       wb_data;
        logic [`REG_ADDR_W-1:0] rd;
        logic                   reg_write;
    } mem_wb_t;

endpackage

//--- design/alu.sv
// Integer ALU for the kept RV32I subset; shifts use only the low 5 bits of b
`timescale 1ns/1ns
`include "rv_core_config.svh"

module alu import rv_core_pkg::*; (
    input  alu_op_e          op,
    input  logic [`XLEN-1:0] a,
    input  logic [`XLEN-1:0] b,
    output logic [`XLEN-1:0] y
);

    logic [4:0] shamt;
    logic       lt;

    assign shamt = b[4:0];
    assign lt    = $signed(a) < $signed(b);    // Signed compare for SLT

    always_comb begin
        case (op)
            ALU_ADD: y = a + b;
            ALU_SUB: y = a - b;
            ALU_AND: y = a & b;
            ALU_OR:  y = a | b;
            ALU_XOR: y = a ^ b;
            ALU_SLL: y = a << shamt;
            ALU_SRL: y = a >> shamt;
            ALU_SRA: y = $unsigned($signed(a) >>> shamt);
            ALU_SLT: y = {{(`XLEN-1){1'b0}}, lt};
            default: y = a + b;
        endcase
    end

endmodule

//--- design/hazard_unit.sv
// Forwarding into EX from MEM then WB; x0 is never forwarded and a load stalls its consumer
`timescale 1ns/1ns
`include "rv_core_config.svh"

module hazard_unit import rv_core_pkg::*; (
    input  logic [`REG_ADDR_W-1:0] ex_rs1,
    input  logic [`REG_ADDR_W-1:0] ex_rs2,
    input  logic [`REG_ADDR_W-1:0] mem_rd,
    input  logic                   mem_reg_write,
    input  logic [`REG_ADDR_W-1:0] wb_rd,
    input  logic                   wb_reg_write,
    input  logic [`REG_ADDR_W-1:0] ex_rd,
    input  logic                   ex_mem_read,
    input  logic [`REG_ADDR_W-1:0] id_rs1,
    input  logic [`REG_ADDR_W-1:0] id_rs2,
    output fwd_sel_e               fwd_a,
    output fwd_sel_e               fwd_b,
    output logic                   load_use
);

    logic mem_live;
    logic wb_live;

    assign mem_live = mem_reg_write && (mem_rd != '0);
    assign wb_live  = wb_reg_write && (wb_rd != '0);

    // Younger result wins
    function automatic fwd_sel_e pick(input logic [`REG_ADDR_W-1:0] rs,
                                      input logic [`REG_ADDR_W-1:0] m_rd,
                                      input logic                   m_live,
                                      input logic [`REG_ADDR_W-1:0] w_rd,
                                      input logic                   w_live);
        if (m_live && m_rd == rs) begin
            return FWD_MEM;
        end else if (w_live && w_rd == rs) begin
            return FWD_WB;
        end
        return FWD_REG;
    endfunction

    assign fwd_a = pick(ex_rs1, mem_rd, mem_live, wb_rd, wb_live);
    assign fwd_b = pick(ex_rs2, mem_rd, mem_live, wb_rd, wb_live);

    assign load_use = ex_mem_read && (ex_rd != '0) && (ex_rd == id_rs1 || ex_rd == id_rs2);

endmodule

//--- design/inst_decoder.sv
// Decodes the kept RV32I subset; any other encoding comes out as a NOP
`timescale 1ns/1ns
`include "rv_core_config.svh"

module inst_decoder import rv_core_pkg::*; (
    input  logic [`XLEN-1:0] inst,
    output id_ex_t           ctrl,
    output logic [`XLEN-1:0] imm
);

    localparam logic [6:0] OP_REG    = 7'b0110011;
    localparam logic [6:0] OP_IMM    = 7'b0010011;
    localparam logic [6:0] OP_LOAD   = 7'b0000011;
    localparam logic [6:0] OP_STORE  = 7'b0100011;
    localparam logic [6:0] OP_BRANCH = 7'b1100011;
    localparam logic [6:0] OP_JAL    = 7'b1101111;
    localparam logic [6:0] OP_JALR   = 7'b1100111;

    logic [2:0]       funct3;
    logic [`XLEN-1:0] imm_i;
    logic [`XLEN-1:0] imm_s;
    logic [`XLEN-1:0] imm_b;
    logic [`XLEN-1:0] imm_j;
    logic [`XLEN-1:0] imm_sh;
    alu_op_e          r_op;
    alu_op_e          i_op;
    logic             r_ok;
    logic             i_ok;

    assign funct3 = inst[14:12];
    assign imm_i  = {{(`XLEN-12){inst[31]}}, inst[31:20]};
    assign imm_s  = {{(`XLEN-12){inst[31]}}, inst[31:25], inst[11:7]};
    assign imm_b  = {{(`XLEN-12){inst[31]}}, inst[7], inst[30:25], inst[11:8], 1'b0};
    assign imm_j  = {{(`XLEN-20){inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};
    assign imm_sh = {{(`XLEN-5){1'b0}}, inst[24:20]};    // Shamt, zero extended

    // Register-register forms
    always_comb begin
        r_ok = 1'b1;
        case (funct3)
            3'b000:  r_op = inst[30] ? ALU_SUB : ALU_ADD;
            3'b010:  r_op = ALU_SLT;
            3'b100:  r_op = ALU_XOR;
            3'b110:  r_op = ALU_OR;
            3'b111:  r_op = ALU_AND;
            default: begin
                r_op = ALU_ADD;
                r_ok = 1'b0;        // Shifts and SLTU not kept
            end
        endcase
    end

    // Register-immediate forms
    always_comb begin
        i_ok = 1'b1;
        case (funct3)
            3'b000:  i_op = ALU_ADD;
            3'b001:  i_op = ALU_SLL;
            3'b010:  i_op = ALU_SLT;
            3'b100:  i_op = ALU_XOR;
            3'b101:  i_op = inst[30] ? ALU_SRA : ALU_SRL;
            3'b110:  i_op = ALU_OR;
            3'b111:  i_op = ALU_AND;
            default: begin
                i_op = ALU_ADD;
                i_ok = 1'b0;        // SLTIU
            end
        endcase
    end

    always_comb begin
        ctrl     = '0;
        imm      = '0;
        ctrl.rs1 = inst[19:15];
        ctrl.rs2 = inst[24:20];
        ctrl.rd  = inst[11:7];
        case (inst[6:0])
            OP_REG: begin
                ctrl.alu_op    = r_op;
                ctrl.reg_write = r_ok;
            end
            OP_IMM: begin
                ctrl.alu_op    = i_op;
                ctrl.alu_src   = 1'b1;
                ctrl.reg_write = i_ok;
                imm            = (funct3[1:0] == 2'b01) ? imm_sh : imm_i;
            end
            OP_LOAD: begin
                ctrl.alu_src   = 1'b1;
                ctrl.mem_read  = (funct3 == 3'b010);    // LW only
                ctrl.reg_write = (funct3 == 3'b010);
                imm            = imm_i;
            end
            OP_STORE: begin
                ctrl.alu_src   = 1'b1;
                ctrl.mem_write = (funct3 == 3'b010);    // SW only
                imm            = imm_s;
            end
            OP_BRANCH: begin
                ctrl.branch    = (funct3[2:1] == 2'b00);
                ctrl.branch_ne = (funct3 == 3'b001);
                imm            = imm_b;
            end
            OP_JAL: begin
                ctrl.jal       = 1'b1;
                ctrl.reg_write = 1'b1;
                imm            = imm_j;
            end
            OP_JALR: begin
                ctrl.jalr      = 1'b1;
                ctrl.alu_src   = 1'b1;   // rs1 + imm through the ALU
                ctrl.reg_write = 1'b1;
                imm            = imm_i;
            end
            default: ctrl.alu_op = ALU_ADD;
        endcase
    end

endmodule

//--- design/reg_file.sv
// Two read ports, one write port; a read of the register being written returns the new value
`timescale 1ns/1ns
`include "rv_core_config.svh"

module reg_file (
    input  logic                   clk,
    input  logic                   RST_n,
    input  logic                   we,
    input  logic [`REG_ADDR_W-1:0] waddr,
    input  logic [`XLEN-1:0]       wdata,
    input  logic [`REG_ADDR_W-1:0] raddr1,
    input  logic [`REG_ADDR_W-1:0] raddr2,
    output logic [`XLEN-1:0]       rdata1,
    output logic [`XLEN-1:0]       rdata2
);

    logic [`XLEN-1:0] regs [`NUM_REGS];
    logic             wr_live;

    assign wr_live = we && (waddr != '0);    // x0 never written

    always_ff @(posedge clk) begin
        if (!RST_n) begin
            for (int i = 0; i < `NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_live) begin
            regs[waddr] <= wdata;
        end
    end

    // Write-through bypass
    assign rdata1 = (wr_live && waddr == raddr1) ? wdata : regs[raddr1];
    assign rdata2 = (wr_live && waddr == raddr2) ? wdata : regs[raddr2];

    x0_reads_zero: assert property (@(posedge clk) disable iff (!RST_n)
        ((raddr1 == '0) -> (rdata1 == '0)) && ((raddr2 == '0) -> (rdata2 == '0)))
        else $error("reg_file x0 read back nonzero");

endmodule

//--- design/stage_reg.sv
// Pipeline register; hold beats flush, and the two must never be raised together
`timescale 1ns/1ns

module stage_reg import rv_core_pkg::*; #(
    parameter type      payload_t = if_id_t,
    parameter payload_t BUBBLE    = '0
) (
    input  logic     clk,
    input  logic     RST_n,
    input  logic     hold,
    input  logic     flush,
    input  payload_t d,
    output payload_t q
);

    always_ff @(posedge clk) begin
        if (!RST_n) begin
            q <= BUBBLE;
        end else if (hold) begin
            q <= q;             // Frozen stage
        end else if (flush) begin
            q <= BUBBLE;        // Squashed instruction
        end else begin
            q <= d;
        end
    end

    hold_flush_excl: assert property (@(posedge clk) disable iff (!RST_n) !(hold && flush))
        else $error("stage_reg hold and flush raised in the same cycle");

endmodule

//--- run_sim.sh
#!/usr/bin/env bash
# Builds the rv_core testbench with Verilator, runs it and checks the log
set -u
cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG=sim.log

verilator --binary --timing --assert -f rv_core.f --top-module tb_rv_core -Mdir "$BUILD_DIR"
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

"./$BUILD_DIR/Vtb_rv_core" > "$LOG" 2>&1
run_status=$?
cat "$LOG"
if [ $run_status -ne 0 ]; then
    echo "Simulation binary returned status $run_status"
    exit 1
fi

if grep -q "Simulation failed" "$LOG"; then
    exit 1
fi
exit 0

//--- rv_core.f
+incdir+common
common/rv_core_pkg.sv
design/stage_reg.sv
design/alu.sv
design/inst_decoder.sv
design/reg_file.sv
design/hazard_unit.sv
rv_core/rv_core.sv
verif/tb_clock_gen.sv
verif/tb_rv_core.sv

//--- rv_core/rv_core.sv
// Memories must answer in the same cycle; dmem_stall freezes the whole pipeline, fetch never stalls
`timescale 1ns/1ns
`include "rv_core_config.svh"

module rv_core import rv_core_pkg::*; (
    input  logic             clk,
    input  logic             RST_n,
    output logic [`XLEN-3:0] imem_addr,
    input  logic [`XLEN-1:0] imem_rdata,
    output logic             dmem_ren,
    output logic             dmem_wen,
    output logic [`XLEN-3:0] dmem_addr,
    output logic [`XLEN-1:0] dmem_wdata,
    input  logic [`XLEN-1:0] dmem_rdata,
    input  logic             dmem_stall,
    output logic [`XLEN-1:0] pc
);

    localparam if_id_t IF_ID_BUBBLE = '{pc: '0, inst: `NOP_INST};

    if_id_t           if_id_d, if_id_q;
    id_ex_t           id_ex_d, id_ex_q;
    ex_mem_t          ex_mem_d, ex_mem_q;
    mem_wb_t          mem_wb_d, mem_wb_q;
    id_ex_t           dec_ctrl;
    logic [`XLEN-1:0] dec_imm;
    logic [`XLEN-1:0] rf_rdata1, rf_rdata2;
    fwd_sel_e         fwd_a, fwd_b;
    logic             load_use;
    logic [`XLEN-1:0] op_a, rs2_fwd, alu_b, alu_y;
    logic [`XLEN-1:0] target, link;
    logic             br_taken, redirect;
    logic             if_id_hold, if_id_flush, id_ex_flush;

    function automatic logic [`XLEN-1:0] fwd_mux(input fwd_sel_e         sel,
                                                 input logic [`XLEN-1:0] rf_val,
                                                 input logic [`XLEN-1:0] mem_val,
                                                 input logic [`XLEN-1:0] wb_val);
        case (sel)
            FWD_MEM: return mem_val;
            FWD_WB:  return wb_val;
            default: return rf_val;
        endcase
    endfunction

    // Stage control
    assign if_id_hold  = dmem_stall || load_use;
    assign if_id_flush = redirect && !if_id_hold;
    assign id_ex_flush = (redirect || load_use) && !dmem_stall;   // Bubble after a load

    // IF
    always_ff @(posedge clk) begin
        if (!RST_n) begin
            pc <= `RESET_PC;
        end else if (!dmem_stall) begin
            if (redirect) begin
                pc <= target;
            end else if (!load_use) begin
                pc <= pc + `XLEN'(4);
            end
        end
    end

    assign imem_addr = pc[`XLEN-1:2];
    assign if_id_d   = '{pc: pc, inst: imem_rdata};

    stage_reg #(.payload_t(if_id_t), .BUBBLE(IF_ID_BUBBLE)) i_if_id (
        .clk(clk), .RST_n(RST_n), .hold(if_id_hold), .flush(if_id_flush),
        .d(if_id_d), .q(if_id_q)
    );

    // ID
    inst_decoder i_dec (.inst(if_id_q.inst), .ctrl(dec_ctrl), .imm(dec_imm));

    reg_file i_rf (
        .clk(clk), .RST_n(RST_n),
        .we(mem_wb_q.reg_write && !dmem_stall), .waddr(mem_wb_q.rd), .wdata(mem_wb_q.wb_data),
        .raddr1(dec_ctrl.rs1), .raddr2(dec_ctrl.rs2),
        .rdata1(rf_rdata1), .rdata2(rf_rdata2)
    );

    always_comb begin
        id_ex_d         = dec_ctrl;
        id_ex_d.pc      = if_id_q.pc;
        id_ex_d.rs1_val = rf_rdata1;
        id_ex_d.rs2_val = rf_rdata2;
        id_ex_d.imm     = dec_imm;
    end

    stage_reg #(.payload_t(id_ex_t)) i_id_ex (
        .clk(clk), .RST_n(RST_n), .hold(dmem_stall), .flush(id_ex_flush),
        .d(id_ex_d), .q(id_ex_q)
    );

    hazard_unit i_hazard (
        .ex_rs1(id_ex_q.rs1), .ex_rs2(id_ex_q.rs2),
        .mem_rd(ex_mem_q.rd), .mem_reg_write(ex_mem_q.reg_write),
        .wb_rd(mem_wb_q.rd), .wb_reg_write(mem_wb_q.reg_write),
        .ex_rd(id_ex_q.rd), .ex_mem_read(id_ex_q.mem_read),
        .id_rs1(dec_ctrl.rs1), .id_rs2(dec_ctrl.rs2),
        .fwd_a(fwd_a), .fwd_b(fwd_b), .load_use(load_use)
    );

    // EX
    assign op_a    = fwd_mux(fwd_a, id_ex_q.rs1_val, ex_mem_q.result, mem_wb_q.wb_data);
    assign rs2_fwd = fwd_mux(fwd_b, id_ex_q.rs2_val, ex_mem_q.result, mem_wb_q.wb_data);
    assign alu_b   = id_ex_q.alu_src ? id_ex_q.imm : rs2_fwd;

    alu i_alu (.op(id_ex_q.alu_op), .a(op_a), .b(alu_b), .y(alu_y));

    assign br_taken = id_ex_q.branch && ((op_a == rs2_fwd) ^ id_ex_q.branch_ne);
    assign redirect = br_taken || id_ex_q.jal || id_ex_q.jalr;
    assign target   = id_ex_q.jalr ? {alu_y[`XLEN-1:1], 1'b0} : id_ex_q.pc + id_ex_q.imm;
    assign link     = id_ex_q.pc + `XLEN'(4);

    always_comb begin
        ex_mem_d.result     = (id_ex_q.jal || id_ex_q.jalr) ? link : alu_y;
        ex_mem_d.store_data = rs2_fwd;
        ex_mem_d.rd         = id_ex_q.rd;
        ex_mem_d.reg_write  = id_ex_q.reg_write;
        ex_mem_d.mem_read   = id_ex_q.mem_read;
        ex_mem_d.mem_write  = id_ex_q.mem_write;
    end

    stage_reg #(.payload_t(ex_mem_t)) i_ex_mem (
        .clk(clk), .RST_n(RST_n), .hold(dmem_stall), .flush(1'b0),
        .d(ex_mem_d), .q(ex_mem_q)
    );

    // MEM request held steady while stalled
    assign dmem_ren   = ex_mem_q.mem_read;
    assign dmem_wen   = ex_mem_q.mem_write;
    assign dmem_addr  = ex_mem_q.result[`XLEN-1:2];
    assign dmem_wdata = ex_mem_q.store_data;

    always_comb begin
        mem_wb_d.wb_data   = ex_mem_q.mem_read ? dmem_rdata : ex_mem_q.result;
        mem_wb_d.rd        = ex_mem_q.rd;
        mem_wb_d.reg_write = ex_mem_q.reg_write;
    end

    stage_reg #(.payload_t(mem_wb_t)) i_mem_wb (
        .clk(clk), .RST_n(RST_n), .hold(dmem_stall), .flush(1'b0),
        .d(mem_wb_d), .q(mem_wb_q)
    );

endmodule

//--- verif/tb_clock_gen.sv
// Free-running clock; each rst_req pulse gives RESET_CYCLES edges of active-low reset
`timescale 1ns/1ns

module tb_clock_gen #(
    parameter int PERIOD_NS    = 4,
    parameter int RESET_CYCLES = 16
) (
    input  logic rst_req,
    output logic clk,
    output logic rst_n
);

    int   count = 0;
    logic req_seen;

    initial begin
        clk = 1'b0;
        forever #(PERIOD_NS / 2) clk = ~clk;
    end

    // Reset moves 1 ns after the edge, like the other driven inputs
    always @(posedge clk) begin
        req_seen = rst_req;
        #1;
        if (req_seen) begin
            count = 0;
        end else if (count < RESET_CYCLES) begin
            count++;
        end
    end

    assign rst_n = (count >= RESET_CYCLES);

endmodule

//--- verif/tb_rv_core.sv
// Testbench for rv_core; only 64 words per memory exist and each program must store exactly once
`timescale 1ns/1ns
`include "rv_core_config.svh"

module tb_rv_core;

    localparam int NUM_TESTS   = 6;
    localparam int MAX_INSTS   = 12;
    localparam int MEM_WORDS   = 64;
    localparam int PERIOD_NS   = 4;
    localparam int ROW_CYCLES  = 200;    // Watchdog budget per table row
    localparam int STORE_LIMIT = 150;    // Cycles allowed to reach the store
    localparam int TAIL_CYCLES = 10;     // Watched for a repeated store
    localparam int PRELOAD_IDX = 8;      // Word read by the load tests
    localparam logic [6:0] OP_IMM  = 7'b0010011;
    localparam logic [6:0] OP_LOAD = 7'b0000011;
    localparam logic [6:0] OP_JALR = 7'b1100111;

    logic        clk;
    logic        rst_n;
    logic        rst_req = 1'b0;
    logic [29:0] imem_addr;
    logic [31:0] imem_rdata;
    logic        dmem_ren;
    logic        dmem_wen;
    logic [29:0] dmem_addr;
    logic [31:0] dmem_wdata;
    logic [31:0] dmem_rdata;
    logic        dmem_stall = 1'b0;
    logic [31:0] pc;

    logic [31:0] imem [MEM_WORDS];
    logic [31:0] dmem [MEM_WORDS];

    // Stimulus and expected store per row
    string       test_name [NUM_TESTS];
    logic [31:0] prog      [NUM_TESTS][MAX_INSTS];
    int          prog_len  [NUM_TESTS];
    logic [31:0] preload   [NUM_TESTS];
    logic        stall_en  [NUM_TESTS];
    logic [31:0] exp_addr  [NUM_TESTS];    // Byte address
    logic [31:0] exp_data  [NUM_TESTS];

    logic        stall_active = 1'b0;
    int          errors = 0;
    int          passed = 0;
    int          failed = 0;

    tb_clock_gen #(.PERIOD_NS(PERIOD_NS), .RESET_CYCLES(16)) i_clk_gen (
        .rst_req(rst_req), .clk(clk), .rst_n(rst_n)
    );

    rv_core i_dut (
        .clk(clk), .RST_n(rst_n),
        .imem_addr(imem_addr), .imem_rdata(imem_rdata),
        .dmem_ren(dmem_ren), .dmem_wen(dmem_wen), .dmem_addr(dmem_addr),
        .dmem_wdata(dmem_wdata), .dmem_rdata(dmem_rdata), .dmem_stall(dmem_stall),
        .pc(pc)
    );

    // Both memories answer in the same cycle
    assign imem_rdata = imem[imem_addr[5:0]];
    assign dmem_rdata = dmem[dmem_addr[5:0]];

    initial begin
        void'($urandom(38439));
        forever begin
            @(posedge clk);
            #1;
            dmem_stall = stall_active && (($urandom % 3) == 0);    // About one cycle in three
        end
    end

    function automatic logic [31:0] r_inst(input logic [6:0] f7, input logic [2:0] f3,
                                           input int rd, input int rs1, input int rs2);
        return {f7, rs2[4:0], rs1[4:0], f3, rd[4:0], 7'b0110011};
    endfunction

    function automatic logic [31:0] i_inst(input logic [6:0] op, input logic [2:0] f3,
                                           input int rd, input int rs1, input int imm);
        return {imm[11:0], rs1[4:0], f3, rd[4:0], op};
    endfunction

    function automatic logic [31:0] sw_inst(input int rs2, input int rs1, input int imm);
        return {imm[11:5], rs2[4:0], rs1[4:0], 3'b010, imm[4:0], 7'b0100011};
    endfunction

    function automatic logic [31:0] branch_inst(input logic [2:0] f3, input int rs1,
                                                input int rs2, input int imm);
        return {imm[12], imm[10:5], rs2[4:0], rs1[4:0], f3, imm[4:1], imm[11], 7'b1100011};
    endfunction

    function automatic logic [31:0] jal_inst(input int rd, input int imm);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd[4:0], 7'b1101111};
    endfunction

    task automatic start_test(input int t, input string name, input logic [31:0] pre,
                              input logic stall, input logic [31:0] addr,
                              input logic [31:0] data);
        test_name[t] = name;
        preload[t]   = pre;
        stall_en[t]  = stall;
        exp_addr[t]  = addr;
        exp_data[t]  = data;
        prog_len[t]  = 0;
    endtask

    task automatic add_inst(input int t, input logic [31:0] word);
        prog[t][prog_len[t]] = word;
        prog_len[t]++;
    endtask

    task automatic build_table();
        // x1 = -7, x2 = 3, then a chain through both forwarding paths
        start_test(0, "rtype_forwarding", 32'h0, 1'b0, 32'h80, 32'h0000_0006);
        add_inst(0, i_inst(OP_IMM, 3'b000, 1, 0, -7));
        add_inst(0, i_inst(OP_IMM, 3'b000, 2, 0, 3));
        add_inst(0, r_inst(7'h00, 3'b000, 3, 1, 2));    // ADD gives -4
        add_inst(0, r_inst(7'h20, 3'b000, 4, 3, 2));    // SUB gives -7
        add_inst(0, r_inst(7'h00, 3'b100, 5, 4, 3));    // XOR gives 5
        add_inst(0, r_inst(7'h00, 3'b010, 6, 4, 5));    // Signed -7 < 5
        add_inst(0, r_inst(7'h00, 3'b000, 7, 6, 5));
        add_inst(0, sw_inst(7, 0, 32'h80));
        add_inst(0, jal_inst(0, 0));
        // -16 >>> 2 = -4, << 1 = -8, | 5 = -3
        start_test(1, "imm_and_shifts", 32'h0, 1'b0, 32'h88, 32'hFFFF_FFFD);
        add_inst(1, i_inst(OP_IMM, 3'b000, 1, 0, -16));
        add_inst(1, i_inst(OP_IMM, 3'b101, 2, 1, 32'h402));    // SRAI by 2
        add_inst(1, i_inst(OP_IMM, 3'b001, 3, 2, 1));
        add_inst(1, i_inst(OP_IMM, 3'b110, 4, 3, 5));
        add_inst(1, sw_inst(4, 0, 32'h88));
        add_inst(1, jal_inst(0, 0));
        start_test(2, "load_use", 32'h1234_5678, 1'b0, 32'h84, 32'h1234_56DC);
        add_inst(2, i_inst(OP_IMM, 3'b000, 3, 0, 100));
        add_inst(2, i_inst(OP_LOAD, 3'b010, 1, 0, PRELOAD_IDX * 4));
        add_inst(2, r_inst(7'h00, 3'b000, 2, 1, 3));    // Needs the loaded word
        add_inst(2, sw_inst(2, 0, 32'h84));
        add_inst(2, jal_inst(0, 0));
        // Markers 1 and 2 sit behind the taken BEQ, 16 and 64 behind the BNE
        start_test(3, "branches", 32'h0, 1'b0, 32'h8C, 32'h0000_0050);
        add_inst(3, i_inst(OP_IMM, 3'b000, 1, 0, 5));
        add_inst(3, i_inst(OP_IMM, 3'b000, 2, 0, 5));
        add_inst(3, branch_inst(3'b000, 1, 2, 12));     // Taken, to 20
        add_inst(3, i_inst(OP_IMM, 3'b000, 3, 3, 1));
        add_inst(3, i_inst(OP_IMM, 3'b000, 3, 3, 2));
        add_inst(3, branch_inst(3'b001, 1, 2, 8));      // Not taken
        add_inst(3, i_inst(OP_IMM, 3'b000, 3, 3, 16));
        add_inst(3, i_inst(OP_IMM, 3'b000, 3, 3, 64));
        add_inst(3, sw_inst(3, 0, 32'h8C));
        add_inst(3, jal_inst(0, 0));
        // Link 8 from JAL at 4, link 20 from JALR at 16, x1 stays 1
        start_test(4, "jal_jalr", 32'h0, 1'b0, 32'h90, 32'h0000_001D);
        add_inst(4, i_inst(OP_IMM, 3'b000, 1, 0, 1));
        add_inst(4, jal_inst(6, 8));
        add_inst(4, i_inst(OP_IMM, 3'b000, 1, 1, 100));
        add_inst(4, i_inst(OP_IMM, 3'b000, 7, 0, 28));
        add_inst(4, i_inst(OP_JALR, 3'b000, 8, 7, 4));  // Lands on 32
        add_inst(4, i_inst(OP_IMM, 3'b000, 1, 1, 200));
        add_inst(4, i_inst(OP_IMM, 3'b000, 1, 1, 300));
        add_inst(4, i_inst(OP_IMM, 3'b000, 1, 1, 400));
        add_inst(4, r_inst(7'h00, 3'b000, 9, 6, 1));
        add_inst(4, r_inst(7'h00, 3'b000, 9, 9, 8));
        add_inst(4, sw_inst(9, 0, 32'h90));
        add_inst(4, jal_inst(0, 0));
        start_test(5, "load_use_stalls", 32'h1234_5678, 1'b1, 32'h84, 32'h1234_56DC);
        for (int j = 0; j < prog_len[2]; j++) begin
            add_inst(5, prog[2][j]);
        end
    endtask

    task automatic fill_memories();
        for (int i = 0; i < MEM_WORDS; i++) begin
            imem[i] = {i[11:0], 20'h00013};    // ADDI x0, x0, i
            dmem[i] = 32'hDA7A_0000 | 32'(i);
        end
    endtask

    task automatic check_value(input string name, input string what,
                               input logic [31:0] expected, input logic [31:0] actual);
        if (expected !== actual) begin
            $display("Mismatch %s %s: expected 0x%08h, actual 0x%08h",
                     name, what, expected, actual);
            errors++;
        end
    endtask

    task automatic run_test(input int t);
        int          cycles;
        int          stores;
        int          errs_before;
        logic        seen;
        logic [31:0] got_addr;
        logic [31:0] got_data;
        cycles      = 0;
        stores      = 0;
        seen        = 1'b0;
        got_addr    = '0;
        got_data    = '0;
        errs_before = errors;
        @(posedge clk);
        #1;
        rst_req = 1'b1;
        @(posedge clk);
        #1;
        rst_req = 1'b0;
        @(posedge clk);
        #1;
        fill_memories();    // Core sits in reset here
        for (int j = 0; j < prog_len[t]; j++) begin
            imem[j] = prog[t][j];
        end
        dmem[PRELOAD_IDX] = preload[t];
        stall_active = stall_en[t];
        wait (rst_n == 1'b1);
        // State left by the last reset edge
        check_value(test_name[t], "pc after reset", `RESET_PC, pc);
        check_value(test_name[t], "dmem_ren after reset", 32'd0, 32'(dmem_ren));
        check_value(test_name[t], "dmem_wen after reset", 32'd0, 32'(dmem_wen));
        while (!seen && cycles < STORE_LIMIT) begin
            @(negedge clk);
            cycles++;
            if (dmem_wen && !dmem_stall) begin
                seen     = 1'b1;
                stores++;
                got_addr = {dmem_addr, 2'b00};
                got_data = dmem_wdata;
                dmem[dmem_addr[5:0]] = dmem_wdata;    // Lands with the coming edge
            end
        end
        if (!seen) begin
            $display("Error: test %s made no store within %0d cycles", test_name[t], STORE_LIMIT);
            errors++;
        end else begin
            repeat (TAIL_CYCLES) begin
                @(negedge clk);
                if (dmem_wen && !dmem_stall) begin
                    stores++;
                end
            end
            check_value(test_name[t], "store address", exp_addr[t], got_addr);
            check_value(test_name[t], "store data", exp_data[t], got_data);
            check_value(test_name[t], "store count", 32'd1, 32'(stores));
        end
        stall_active = 1'b0;
        if (errors == errs_before) begin
            $display("PASS %s", test_name[t]);
            passed++;
        end else begin
            $display("FAIL %s with %0d errors", test_name[t], errors - errs_before);
            failed++;
        end
    endtask

    initial begin
        fill_memories();
        build_table();
        for (int t = 0; t < NUM_TESTS; t++) begin
            run_test(t);
        end
        $display("Tests run: %0d, passed: %0d, failed: %0d", NUM_TESTS, passed, failed);
        if (failed == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

    initial begin
        #(NUM_TESTS * ROW_CYCLES * PERIOD_NS);
        $display("Error: watchdog expired after %0d cycles", NUM_TESTS * ROW_CYCLES);
        $display("Simulation failed");
        $finish;
    end

endmodule
